// File: hw/axi_flit_pkg.sv
package axi_flit_pkg;

  // AXI4 field types
  typedef logic [7:0]  axi_id_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  axi_strb_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  // Address beat, shared by AW and AR
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef enum logic [2:0] {
    CH_AW,
    CH_W,
    CH_B,
    CH_AR,
    CH_R
  } axi_channel_e;

  // Sized by the R beat, the widest channel
  localparam int FLIT_DATA_WIDTH = $bits(axi_r_t);

  // Channel views of the payload, padded at the top
  typedef struct packed {
    logic [FLIT_DATA_WIDTH-$bits(axi_ax_t)-1:0] pad;
    axi_ax_t                                    body;
  } flit_ax_t;

  typedef struct packed {
    logic [FLIT_DATA_WIDTH-$bits(axi_w_t)-1:0] pad;
    axi_w_t                                    body;
  } flit_w_t;

  typedef struct packed {
    logic [FLIT_DATA_WIDTH-$bits(axi_b_t)-1:0] pad;
    axi_b_t                                    body;
  } flit_b_t;

  typedef struct packed {
    axi_r_t body;
  } flit_r_t;

  // One word, decoded by the channel code
  typedef union packed {
    flit_ax_t ax;
    flit_w_t  w;
    flit_b_t  b;
    flit_r_t  r;
  } flit_payload_u;

  typedef struct packed {
    logic          valid;
    logic          tail;
    axi_channel_e  channel;
    flit_payload_u payload;
  } flit_t;

endpackage

// File: hw/axi_master_bridge.sv
`timescale 1ns/100ps

module axi_master_bridge import axi_flit_pkg::*; (
  input  logic    CLK,
  input  logic    RST_N,

  // Upstream AXI from the master
  input  axi_ax_t s_aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  s_w,
  input  logic    w_valid,
  output logic    w_ready,
  input  axi_ax_t s_ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_b_t  s_b,
  output logic    b_valid,
  input  logic    b_ready,
  output axi_r_t  s_r,
  output logic    r_valid,
  input  logic    r_ready,

  // Flit links
  output flit_t   req_flit,
  input  logic    req_ready,
  input  flit_t   rsp_flit,
  output logic    rsp_ready
);

  typedef enum logic [2:0] {
    IDLE,
    WDATA,
    WRESP_WAIT,
    WRESP,
    RDATA_WAIT,
    RDATA
  } state_e;

  state_e state;
  state_e next_state;
  flit_t  rsp_q;
  logic   aw_fire;
  logic   w_fire;
  logic   ar_fire;
  logic   b_fire;
  logic   r_fire;
  logic   rsp_fire;

  // AW wins over AR when both are offered in IDLE
  assign aw_ready = (state == IDLE) && req_ready;
  assign ar_ready = (state == IDLE) && req_ready && !aw_valid;
  assign w_ready  = (state == WDATA) && req_ready;

  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;
  assign ar_fire  = ar_valid && ar_ready;
  assign b_fire   = b_valid && b_ready;
  assign r_fire   = r_valid && r_ready;
  assign rsp_fire = rsp_flit.valid && rsp_ready;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (aw_fire) begin
          next_state = WDATA;
        end else if (ar_fire) begin
          next_state = RDATA_WAIT;
        end
      end
      WDATA: begin
        if (w_fire && s_w.last) begin
          next_state = WRESP_WAIT;
        end
      end
      WRESP_WAIT: begin
        if (rsp_fire) begin
          next_state = WRESP;
        end
      end
      WRESP: begin
        if (b_fire) begin
          next_state = IDLE;
        end
      end
      RDATA_WAIT: begin
        if (rsp_fire) begin
          next_state = RDATA;
        end
      end
      RDATA: begin
        if (r_fire) begin
          next_state = rsp_q.tail ? IDLE : RDATA_WAIT;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // Request flit goes out in the cycle of the AXI handshake
  always_comb begin
    req_flit       = '0;
    req_flit.valid = aw_fire || w_fire || ar_fire;
    req_flit.tail  = ar_fire || (w_fire && s_w.last);
    if (aw_fire) begin
      req_flit.channel         = CH_AW;
      req_flit.payload.ax.body = s_aw;
    end else if (w_fire) begin
      req_flit.channel        = CH_W;
      req_flit.payload.w.body = s_w;
    end else if (ar_fire) begin
      req_flit.channel         = CH_AR;
      req_flit.payload.ax.body = s_ar;
    end
  end

  assign rsp_ready = (state == WRESP_WAIT) || (state == RDATA_WAIT);

  always_ff @(posedge CLK) begin
    if (rsp_fire) begin
      rsp_q <= rsp_flit;
    end
  end

  assign s_b     = rsp_q.payload.b.body;
  assign b_valid = (state == WRESP);
  assign s_r     = rsp_q.payload.r.body;
  assign r_valid = (state == RDATA);

  // B answers a write, R answers a read
  a_rsp_matches_state: assert property (
    @(posedge CLK) disable iff (!RST_N)
    rsp_fire |-> (rsp_flit.channel == CH_B) == (state == WRESP_WAIT)
  );

  // Only the slave bridge drives this link
  a_rsp_channel: assert property (
    @(posedge CLK) disable iff (!RST_N)
    rsp_flit.valid |-> (rsp_flit.channel == CH_B) || (rsp_flit.channel == CH_R)
  );

endmodule

// File: hw/axi_slave_bridge.sv
`timescale 1ns/100ps

module axi_slave_bridge import axi_flit_pkg::*; (
  input  logic    CLK,
  input  logic    RST_N,

  // Downstream AXI to the slave
  output axi_ax_t m_aw,
  output logic    aw_valid,
  input  logic    aw_ready,
  output axi_w_t  m_w,
  output logic    w_valid,
  input  logic    w_ready,
  output axi_ax_t m_ar,
  output logic    ar_valid,
  input  logic    ar_ready,
  input  axi_b_t  m_b,
  input  logic    b_valid,
  output logic    b_ready,
  input  axi_r_t  m_r,
  input  logic    r_valid,
  output logic    r_ready,

  // Flit links
  input  flit_t   req_flit,
  output logic    req_ready,
  output flit_t   rsp_flit,
  input  logic    rsp_ready
);

  typedef enum logic [2:0] {
    IDLE,
    WADDR,
    WDATA_WAIT,
    WDATA,
    WRESP,
    RADDR,
    RDATA
  } state_e;

  state_e state;
  state_e next_state;
  flit_t  req_q;
  logic   req_fire;
  logic   aw_fire;
  logic   w_fire;
  logic   ar_fire;
  logic   b_fire;
  logic   r_fire;

  assign req_ready = (state == IDLE) || (state == WDATA_WAIT);
  assign req_fire  = req_flit.valid && req_ready;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign ar_fire = ar_valid && ar_ready;
  assign b_fire  = b_valid && b_ready;
  assign r_fire  = r_valid && r_ready;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        // Channel code picks the write or the read path
        if (req_fire) begin
          if (req_flit.channel == CH_AW) begin
            next_state = WADDR;
          end else if (req_flit.channel == CH_AR) begin
            next_state = RADDR;
          end
        end
      end
      WADDR: begin
        if (aw_fire) begin
          next_state = WDATA_WAIT;
        end
      end
      WDATA_WAIT: begin
        if (req_fire) begin
          next_state = WDATA;
        end
      end
      WDATA: begin
        if (w_fire) begin
          next_state = req_q.tail ? WRESP : WDATA_WAIT;
        end
      end
      WRESP: begin
        if (b_fire) begin
          next_state = IDLE;
        end
      end
      RADDR: begin
        if (ar_fire) begin
          next_state = RDATA;
        end
      end
      RDATA: begin
        if (r_fire && m_r.last) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (req_fire) begin
      req_q <= req_flit;
    end
  end

  // Held request flit drives the downstream channels
  assign m_aw     = req_q.payload.ax.body;
  assign aw_valid = (state == WADDR);
  assign m_w      = req_q.payload.w.body;
  assign w_valid  = (state == WDATA);
  assign m_ar     = req_q.payload.ax.body;
  assign ar_valid = (state == RADDR);

  // Responses only move while the link can take them
  assign b_ready = (state == WRESP) && rsp_ready;
  assign r_ready = (state == RDATA) && rsp_ready;

  always_comb begin
    rsp_flit       = '0;
    rsp_flit.valid = b_fire || r_fire;
    rsp_flit.tail  = b_fire || (r_fire && m_r.last);
    if (b_fire) begin
      rsp_flit.channel        = CH_B;
      rsp_flit.payload.b.body = m_b;
    end else if (r_fire) begin
      rsp_flit.channel        = CH_R;
      rsp_flit.payload.r.body = m_r;
    end
  end

  // Master bridge sends AW ahead of any W
  a_no_w_in_idle: assert property (
    @(posedge CLK) disable iff (!RST_N)
    (state == IDLE) && req_flit.valid |-> req_flit.channel != CH_W
  );

  // Only W flits follow an accepted AW
  a_w_after_aw: assert property (
    @(posedge CLK) disable iff (!RST_N)
    (state == WDATA_WAIT) && req_flit.valid |-> req_flit.channel == CH_W
  );

endmodule

// File: hw/axi_flit_tunnel.sv
`timescale 1ns/100ps

module axi_flit_tunnel import axi_flit_pkg::*; (
  input  logic    CLK,
  input  logic    RST_N,

  // Upstream AXI, from the master
  input  axi_ax_t up_s_aw,
  input  logic    up_aw_valid,
  output logic    up_aw_ready,
  input  axi_w_t  up_s_w,
  input  logic    up_w_valid,
  output logic    up_w_ready,
  input  axi_ax_t up_s_ar,
  input  logic    up_ar_valid,
  output logic    up_ar_ready,
  output axi_b_t  up_s_b,
  output logic    up_b_valid,
  input  logic    up_b_ready,
  output axi_r_t  up_s_r,
  output logic    up_r_valid,
  input  logic    up_r_ready,

  // Downstream AXI, to the slave
  output axi_ax_t dn_m_aw,
  output logic    dn_aw_valid,
  input  logic    dn_aw_ready,
  output axi_w_t  dn_m_w,
  output logic    dn_w_valid,
  input  logic    dn_w_ready,
  output axi_ax_t dn_m_ar,
  output logic    dn_ar_valid,
  input  logic    dn_ar_ready,
  input  axi_b_t  dn_m_b,
  input  logic    dn_b_valid,
  output logic    dn_b_ready,
  input  axi_r_t  dn_m_r,
  input  logic    dn_r_valid,
  output logic    dn_r_ready
);

  // Point-to-point links between the bridges
  flit_t req_flit;
  logic  req_ready;
  flit_t rsp_flit;
  logic  rsp_ready;

  axi_master_bridge i_master_bridge (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .s_aw      (up_s_aw),
    .aw_valid  (up_aw_valid),
    .aw_ready  (up_aw_ready),
    .s_w       (up_s_w),
    .w_valid   (up_w_valid),
    .w_ready   (up_w_ready),
    .s_ar      (up_s_ar),
    .ar_valid  (up_ar_valid),
    .ar_ready  (up_ar_ready),
    .s_b       (up_s_b),
    .b_valid   (up_b_valid),
    .b_ready   (up_b_ready),
    .s_r       (up_s_r),
    .r_valid   (up_r_valid),
    .r_ready   (up_r_ready),
    .req_flit  (req_flit),
    .req_ready (req_ready),
    .rsp_flit  (rsp_flit),
    .rsp_ready (rsp_ready)
  );

  axi_slave_bridge i_slave_bridge (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .m_aw      (dn_m_aw),
    .aw_valid  (dn_aw_valid),
    .aw_ready  (dn_aw_ready),
    .m_w       (dn_m_w),
    .w_valid   (dn_w_valid),
    .w_ready   (dn_w_ready),
    .m_ar      (dn_m_ar),
    .ar_valid  (dn_ar_valid),
    .ar_ready  (dn_ar_ready),
    .m_b       (dn_m_b),
    .b_valid   (dn_b_valid),
    .b_ready   (dn_b_ready),
    .m_r       (dn_m_r),
    .r_valid   (dn_r_valid),
    .r_ready   (dn_r_ready),
    .req_flit  (req_flit),
    .req_ready (req_ready),
    .rsp_flit  (rsp_flit),
    .rsp_ready (rsp_ready)
  );

endmodule

// File: verification/axi_mem_slave.sv
`timescale 1ns/100ps

module axi_mem_slave import axi_flit_pkg::*; #(
  parameter int          MEM_WORDS = 256,
  parameter logic [31:0] SEED      = 32'h1
) (
  input  logic    CLK,
  input  logic    RST_N,
  input  axi_ax_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  input  axi_ax_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_AW,
    ST_W,
    ST_B,
    ST_AR,
    ST_R
  } state_e;

  axi_data_t mem [MEM_WORDS];
  state_e    state;
  integer    seed;
  int        delay;
  axi_addr_t addr;
  axi_id_t   id;
  axi_len_t  len;
  axi_size_t size;
  axi_len_t  beat;
  logic      err;

  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  initial begin : model
    axi_addr_t fill_addr;
    int        i;
    int        k;
    logic      rst_seen;
    logic      aw_seen;
    logic      ar_seen;
    logic      aw_hs;
    logic      w_hs;
    logic      ar_hs;
    logic      b_hs;
    logic      r_hs;
    axi_ax_t   aw_s;
    axi_ax_t   ar_s;
    axi_w_t    w_s;
    seed     = SEED;
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    ar_ready = 1'b0;
    b_valid  = 1'b0;
    r_valid  = 1'b0;
    b        = '0;
    r        = '0;
    state    = ST_IDLE;
    delay    = 0;
    // Fill word built from the full byte address
    for (i = 0; i < MEM_WORDS; i++) begin
      fill_addr = i * 8;
      mem[i]    = {fill_addr ^ 32'h5a5a_0000, ~fill_addr};
    end
    forever begin
      @(posedge CLK);
      rst_seen = RST_N;
      aw_seen  = aw_valid;
      ar_seen  = ar_valid;
      aw_hs    = aw_valid && aw_ready;
      w_hs     = w_valid && w_ready;
      ar_hs    = ar_valid && ar_ready;
      b_hs     = b_valid && b_ready;
      r_hs     = r_valid && r_ready;
      aw_s     = aw;
      ar_s     = ar;
      w_s      = w;
      #1;
      if (!rst_seen) begin
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        ar_ready = 1'b0;
        b_valid  = 1'b0;
        r_valid  = 1'b0;
        state    = ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            delay = pick_delay();
            if (aw_seen) begin
              state = ST_AW;
            end else if (ar_seen) begin
              state = ST_AR;
            end
          end
          ST_AW, ST_AR: begin
            if (aw_hs || ar_hs) begin
              aw_ready = 1'b0;
              ar_ready = 1'b0;
              addr     = aw_hs ? aw_s.addr : ar_s.addr;
              id       = aw_hs ? aw_s.id : ar_s.id;
              len      = aw_hs ? aw_s.len : ar_s.len;
              size     = aw_hs ? aw_s.size : ar_s.size;
              beat     = '0;
              err      = 1'b0;
              delay    = pick_delay();
              state    = aw_hs ? ST_W : ST_R;
            end else if (delay == 0) begin
              aw_ready = (state == ST_AW);
              ar_ready = (state == ST_AR);
            end else begin
              delay--;
            end
          end
          ST_W: begin
            if (w_hs) begin
              w_ready = 1'b0;
              if (addr < MEM_WORDS * 8) begin
                for (k = 0; k < 8; k++) begin
                  if (w_s.strb[k]) begin
                    mem[addr >> 3][8*k +: 8] = w_s.data[8*k +: 8];
                  end
                end
              end else begin
                err = 1'b1;
              end
              addr  = addr + (32'd1 << size);
              delay = pick_delay();
              if (w_s.last) begin
                state = ST_B;
              end
            end else if (delay == 0) begin
              w_ready = 1'b1;
            end else begin
              delay--;
            end
          end
          ST_B: begin
            if (b_hs) begin
              b_valid = 1'b0;
              state   = ST_IDLE;
            end else if (!b_valid && delay == 0) begin
              b_valid = 1'b1;
              b.id    = id;
              b.resp  = err ? 2'b10 : 2'b00;
            end else if (!b_valid) begin
              delay--;
            end
          end
          ST_R: begin
            if (r_hs) begin
              r_valid = 1'b0;
              addr    = addr + (32'd1 << size);
              delay   = pick_delay();
              if (beat == len) begin
                state = ST_IDLE;
              end else begin
                beat++;
              end
            end else if (!r_valid && delay == 0) begin
              r_valid = 1'b1;
              r.id    = id;
              r.last  = (beat == len);
              if (addr < MEM_WORDS * 8) begin
                r.data = mem[addr >> 3];
                r.resp = 2'b00;
              end else begin
                r.data = '0;
                r.resp = 2'b10;
              end
            end else if (!r_valid) begin
              delay--;
            end
          end
          default: state = ST_IDLE;
        endcase
      end
    end
  end

endmodule

// File: verification/tb_axi_flit_tunnel.sv
`timescale 1ns/100ps

module tb_axi_flit_tunnel import axi_flit_pkg::*; ();

  localparam int          MEM_WORDS = 256;
  localparam int          TIMEOUT   = 2000;
  localparam logic [31:0] SEED      = 32'h82a6;

  logic    CLK;
  logic    RST_N;
  axi_ax_t up_s_aw;
  logic    up_aw_valid;
  logic    up_aw_ready;
  axi_w_t  up_s_w;
  logic    up_w_valid;
  logic    up_w_ready;
  axi_ax_t up_s_ar;
  logic    up_ar_valid;
  logic    up_ar_ready;
  axi_b_t  up_s_b;
  logic    up_b_valid;
  logic    up_b_ready;
  axi_r_t  up_s_r;
  logic    up_r_valid;
  logic    up_r_ready;
  axi_ax_t dn_m_aw;
  logic    dn_aw_valid;
  logic    dn_aw_ready;
  axi_w_t  dn_m_w;
  logic    dn_w_valid;
  logic    dn_w_ready;
  axi_ax_t dn_m_ar;
  logic    dn_ar_valid;
  logic    dn_ar_ready;
  axi_b_t  dn_m_b;
  logic    dn_b_valid;
  logic    dn_b_ready;
  axi_r_t  dn_m_r;
  logic    dn_r_valid;
  logic    dn_r_ready;

  integer    seed = SEED;
  logic      rand_ready = 1'b0;
  int        errors = 0;
  int        checks = 0;
  int        beats_expected = 0;
  int        beats_seen = 0;
  axi_data_t shadow [MEM_WORDS];
  axi_data_t beat_data [4];
  axi_strb_t beat_strb [4];
  axi_b_t    exp_b [$];
  axi_r_t    exp_r [$];

  initial begin
    CLK = 1'b0;
    forever begin
      #4 CLK = ~CLK;
    end
  end

  axi_flit_tunnel i_axi_flit_tunnel (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .up_s_aw     (up_s_aw),
    .up_aw_valid (up_aw_valid),
    .up_aw_ready (up_aw_ready),
    .up_s_w      (up_s_w),
    .up_w_valid  (up_w_valid),
    .up_w_ready  (up_w_ready),
    .up_s_ar     (up_s_ar),
    .up_ar_valid (up_ar_valid),
    .up_ar_ready (up_ar_ready),
    .up_s_b      (up_s_b),
    .up_b_valid  (up_b_valid),
    .up_b_ready  (up_b_ready),
    .up_s_r      (up_s_r),
    .up_r_valid  (up_r_valid),
    .up_r_ready  (up_r_ready),
    .dn_m_aw     (dn_m_aw),
    .dn_aw_valid (dn_aw_valid),
    .dn_aw_ready (dn_aw_ready),
    .dn_m_w      (dn_m_w),
    .dn_w_valid  (dn_w_valid),
    .dn_w_ready  (dn_w_ready),
    .dn_m_ar     (dn_m_ar),
    .dn_ar_valid (dn_ar_valid),
    .dn_ar_ready (dn_ar_ready),
    .dn_m_b      (dn_m_b),
    .dn_b_valid  (dn_b_valid),
    .dn_b_ready  (dn_b_ready),
    .dn_m_r      (dn_m_r),
    .dn_r_valid  (dn_r_valid),
    .dn_r_ready  (dn_r_ready)
  );

  axi_mem_slave #(
    .MEM_WORDS (MEM_WORDS),
    .SEED      (SEED)
  ) i_mem_slave (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .aw       (dn_m_aw),
    .aw_valid (dn_aw_valid),
    .aw_ready (dn_aw_ready),
    .w        (dn_m_w),
    .w_valid  (dn_w_valid),
    .w_ready  (dn_w_ready),
    .ar       (dn_m_ar),
    .ar_valid (dn_ar_valid),
    .ar_ready (dn_ar_ready),
    .b        (dn_m_b),
    .b_valid  (dn_b_valid),
    .b_ready  (dn_b_ready),
    .r        (dn_m_r),
    .r_valid  (dn_r_valid),
    .r_ready  (dn_r_ready)
  );

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR: %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    $display("Timeout: no %s within %0d clock cycles", what, TIMEOUT);
    errors++;
    finish_run();
  endtask

  function automatic axi_data_t merge_bytes(input axi_data_t old, input axi_data_t data,
                                            input axi_strb_t strb);
    axi_data_t mask;
    int        k;
    for (k = 0; k < 8; k++) begin
      mask[8*k +: 8] = {8{strb[k]}};
    end
    return (old & ~mask) | (data & mask);
  endfunction

  // Applies a write burst to the shadow memory and returns the expected B
  function automatic axi_b_t model_write(input axi_id_t id, input axi_addr_t addr,
                                         input axi_len_t len);
    axi_b_t    b;
    axi_addr_t a;
    int        i;
    b.id   = id;
    b.resp = 2'b00;
    for (i = 0; i <= len; i++) begin
      a = addr + i * 8;
      if (a < MEM_WORDS * 8) begin
        shadow[a / 8] = merge_bytes(shadow[a / 8], beat_data[i], beat_strb[i]);
      end else begin
        // One bad beat makes the whole burst SLVERR
        b.resp = 2'b10;
      end
    end
    return b;
  endfunction

  function automatic axi_r_t predict_read(input axi_id_t id, input axi_addr_t addr,
                                          input int beat, input axi_len_t len);
    axi_r_t    r;
    axi_addr_t a;
    a      = addr + beat * 8;
    r.id   = id;
    r.last = (beat == len);
    if (a < MEM_WORDS * 8) begin
      r.data = shadow[a / 8];
      r.resp = 2'b00;
    end else begin
      r.data = '0;
      r.resp = 2'b10;
    end
    return r;
  endfunction

  task automatic await_ready(input string what, input int sel);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge CLK);
      case (sel)
        0: seen = up_aw_ready;
        1: seen = up_w_ready;
        default: seen = up_ar_ready;
      endcase
      n++;
      if (!seen && n >= TIMEOUT) begin
        abort_timeout(what);
      end
    end
    #1;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      @(posedge CLK);
      #1;
      n++;
      if (n >= TIMEOUT) begin
        abort_timeout("B or R response");
      end
    end
  endtask

  task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
    axi_ax_t ax;
    int      i;
    ax.id    = id;
    ax.addr  = addr;
    ax.len   = len;
    ax.size  = 3'd3;
    ax.burst = 2'b01;
    exp_b.push_back(model_write(id, addr, len));
    beats_expected++;
    up_s_aw     = ax;
    up_aw_valid = 1'b1;
    await_ready("AW handshake", 0);
    up_aw_valid = 1'b0;
    for (i = 0; i <= len; i++) begin
      up_s_w.data = beat_data[i];
      up_s_w.strb = beat_strb[i];
      up_s_w.last = (i == len);
      up_w_valid  = 1'b1;
      await_ready("W handshake", 1);
      up_w_valid = 1'b0;
    end
    wait_idle();
  endtask

  task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
    axi_ax_t ax;
    int      i;
    ax.id    = id;
    ax.addr  = addr;
    ax.len   = len;
    ax.size  = 3'd3;
    ax.burst = 2'b01;
    for (i = 0; i <= len; i++) begin
      exp_r.push_back(predict_read(id, addr, i, len));
    end
    beats_expected += len + 1;
    up_s_ar     = ax;
    up_ar_valid = 1'b1;
    await_ready("AR handshake", 2);
    up_ar_valid = 1'b0;
    wait_idle();
  endtask

  task automatic run_random(input int count);
    int        n;
    int        i;
    logic      is_write;
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
    for (n = 0; n < count; n++) begin
      is_write = $random(seed) & 1;
      id       = $random(seed) & 8'hff;
      // Window around the top of memory reaching past its end
      addr     = (MEM_WORDS - 16 + {$random(seed)} % 24) * 8;
      len      = $random(seed) & 3;
      if (is_write) begin
        for (i = 0; i < 4; i++) begin
          beat_data[i] = {$random(seed), $random(seed)};
          beat_strb[i] = $random(seed) & 8'hff;
        end
        write_burst(id, addr, len);
      end else begin
        read_burst(id, addr, len);
      end
    end
  endtask

  // Upstream B and R ready is random only while rand_ready is set
  initial begin : ready_driver
    logic b_next;
    logic r_next;
    forever begin
      @(negedge CLK);
      b_next = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
      r_next = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
      @(posedge CLK);
      #1;
      up_b_ready = b_next;
      up_r_ready = r_next;
    end
  end

  initial begin : compare
    axi_b_t b_exp;
    axi_r_t r_exp;
    forever begin
      @(posedge CLK);
      // One request in flight, so the upstream AW or AR is still on the bus
      if (dn_aw_valid && dn_aw_ready) begin
        check_value("dn aw", dn_m_aw, up_s_aw);
      end
      if (dn_ar_valid && dn_ar_ready) begin
        check_value("dn ar", dn_m_ar, up_s_ar);
      end
      if (up_b_valid && up_b_ready) begin
        beats_seen++;
        if (exp_b.size() == 0) begin
          $display("Unexpected B beat at %0t ns with no write outstanding", $time);
          errors++;
        end else begin
          b_exp = exp_b.pop_front();
          check_value("bid", up_s_b.id, b_exp.id);
          check_value("bresp", up_s_b.resp, b_exp.resp);
        end
      end
      if (up_r_valid && up_r_ready) begin
        beats_seen++;
        if (exp_r.size() == 0) begin
          $display("Unexpected R beat at %0t ns with no read outstanding", $time);
          errors++;
        end else begin
          r_exp = exp_r.pop_front();
          check_value("rid", up_s_r.id, r_exp.id);
          check_value("rdata", up_s_r.data, r_exp.data);
          check_value("rresp", up_s_r.resp, r_exp.resp);
          check_value("rlast", up_s_r.last, r_exp.last);
        end
      end
    end
  end

  initial begin : stimulus
    axi_addr_t fill_addr;
    int        i;
    RST_N       = 1'b0;
    up_s_aw     = '0;
    up_aw_valid = 1'b0;
    up_s_w      = '0;
    up_w_valid  = 1'b0;
    up_s_ar     = '0;
    up_ar_valid = 1'b0;
    up_b_ready  = 1'b1;
    up_r_ready  = 1'b1;
    for (i = 0; i < MEM_WORDS; i++) begin
      fill_addr = i * 8;
      shadow[i] = {fill_addr ^ 32'h5a5a_0000, ~fill_addr};
    end
    repeat (8) @(posedge CLK);
    #1;
    RST_N = 1'b1;

    check_value("up wready after reset", up_w_ready, 1'b0);
    check_value("up bvalid after reset", up_b_valid, 1'b0);
    check_value("up rvalid after reset", up_r_valid, 1'b0);
    check_value("dn awvalid after reset", dn_aw_valid, 1'b0);
    check_value("dn wvalid after reset", dn_w_valid, 1'b0);
    check_value("dn arvalid after reset", dn_ar_valid, 1'b0);

    // Single beat
    beat_data[0] = 64'h0123_4567_89ab_cdef;
    beat_strb[0] = 8'hff;
    write_burst(8'h11, 32'h40, 8'd0);
    read_burst(8'h12, 32'h40, 8'd0);

    // Four beat burst with mixed strobes
    beat_data[0] = 64'h1111_2222_3333_4444;
    beat_data[1] = 64'h5555_6666_7777_8888;
    beat_data[2] = 64'h9999_aaaa_bbbb_cccc;
    beat_data[3] = 64'hdddd_eeee_ffff_0000;
    beat_strb[0] = 8'hff;
    beat_strb[1] = 8'h0f;
    beat_strb[2] = 8'hf0;
    beat_strb[3] = 8'h5a;
    write_burst(8'h21, 32'h100, 8'd3);
    read_burst(8'h22, 32'h100, 8'd3);

    // Out of range, then a burst across the end of memory
    write_burst(8'h31, MEM_WORDS * 8 + 32'h20, 8'd0);
    read_burst(8'h32, MEM_WORDS * 8 + 32'h20, 8'd0);
    write_burst(8'h33, MEM_WORDS * 8 - 16, 8'd3);
    read_burst(8'h34, MEM_WORDS * 8 - 16, 8'd3);

    rand_ready = 1'b1;
    run_random(20);
    rand_ready = 1'b0;
    check_value("response beat count", beats_seen, beats_expected);
    finish_run();
  end

endmodule

// File: build.f
hw/axi_flit_pkg.sv
hw/axi_master_bridge.sv
hw/axi_slave_bridge.sv
hw/axi_flit_tunnel.sv
verification/axi_mem_slave.sv
verification/tb_axi_flit_tunnel.sv
